// ==== fp_noncomp_slice.f ====
hdl/fp_fmt_pkg.sv
hdl/slice_op_pkg.sv
hdl/slice_pipe_ctrl.sv
hdl/lane_operand_prep.sv
hdl/noncomp_lane.sv
hdl/result_pack.sv
hdl/fp_noncomp_slice.sv
dv/tb_fp_noncomp_slice.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator; the verdict comes from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_fp_noncomp_slice \
  -f fp_noncomp_slice.f \
  -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }

// ==== dv/tb_fp_noncomp_slice.sv ====
// ---------------------------------------------------------------------
// Testbench for the FP32/FP16 non-computational SIMD slice
// Inputs change on the falling edge and outputs are sampled before
// the next rising edge. Flush and latency checks assume NumPipeRegs > 0
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_fp_noncomp_slice;

  localparam int unsigned N_PIPE = 2;
  localparam logic [4:0]  NV     = 5'b1_0000;

  typedef struct packed {
    slice_op_pkg::slice_req_t req;
    logic [31:0]              exp_result;
    fp_fmt_pkg::status_t      exp_status;
  } vector_t;

  typedef struct packed {
    logic [3:0]          tag;
    logic [31:0]         result;
    fp_fmt_pkg::status_t status;
  } expect_t;

  logic                     clk_i, arst_n_i, in_valid_i, in_ready_o, flush_i;
  logic                     out_valid_o, out_ready_i, busy_o, extension_bit_o;
  slice_op_pkg::slice_req_t req_i;
  logic [3:0]               tag_i, tag_o;
  logic [31:0]              result_o;
  fp_fmt_pkg::status_t      status_o;

  vector_t tbl[$];
  string   tbl_name[$];
  expect_t exp_q[$];
  string   exp_name_q[$];

  logic [3:0] next_tag;
  int         ready_mode;
  int         mismatch_errs;
  int         other_errs;
  bit         table_built;

  fp_noncomp_slice #(
    .NumPipeRegs (N_PIPE),
    .tag_t       (logic [3:0])
  ) DUT (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_i           (req_i),
    .tag_i           (tag_i),
    .in_valid_i      (in_valid_i),
    .in_ready_o      (in_ready_o),
    .flush_i         (flush_i),
    .result_o        (result_o),
    .status_o        (status_o),
    .extension_bit_o (extension_bit_o),
    .tag_o           (tag_o),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .busy_o          (busy_o)
  );

  always #5 clk_i = ~clk_i;

  // -------------------------------------------------------------------
  // Stimulus helpers
  // -------------------------------------------------------------------
  task automatic add_vector(input string name, input slice_op_pkg::noncomp_op_e op,
                            input fp_fmt_pkg::fp_fmt_e fmt, input logic vec,
                            input logic [1:0] mask, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] res,
                            input logic [4:0] sts);
    vector_t v;
    v.req.op        = op;
    v.req.fmt       = fmt;
    v.req.vectorial = vec;
    v.req.simd_mask = mask;
    v.req.a         = a;
    v.req.b         = b;
    v.exp_result    = res;
    v.exp_status    = fp_fmt_pkg::status_t'(sts);
    tbl.push_back(v);
    tbl_name.push_back(name);
  endtask

  // Holds the request until it is taken, then books its expected output
  task automatic apply_entry(input int idx, input bit expect_out);
    expect_t e;
    @(negedge clk_i);
    req_i      = tbl[idx].req;
    tag_i      = next_tag;
    in_valid_i = 1'b1;
    #1;
    while (!in_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    if (expect_out) begin
      e.tag    = next_tag;
      e.result = tbl[idx].exp_result;
      e.status = tbl[idx].exp_status;
      exp_q.push_back(e);
      exp_name_q.push_back(tbl_name[idx]);
    end
    next_tag = next_tag + 4'd1;
  endtask

  task automatic idle_inputs();
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || busy_o) begin
      @(negedge clk_i);
      #3;
    end
  endtask

  task automatic check_latency();
    int lat;
    lat = 0;
    apply_entry(0, 1'b1);
    while (!out_valid_o && lat <= int'(N_PIPE) + 4) begin
      @(negedge clk_i);
      in_valid_i = 1'b0;
      #1;
      lat = lat + 1;
    end
    if (lat != int'(N_PIPE)) begin
      mismatch_errs++;
      $display("MISMATCH latency: expected %0d actual %0d", N_PIPE, lat);
    end
    idle_inputs();
  endtask

  // Two operations are parked with the output stalled, then dropped
  task automatic check_flush();
    apply_entry(1, 1'b0);
    apply_entry(2, 1'b0);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    #1;
    if (!busy_o) begin
      other_errs++;
      $display("busy_o was low while operations were in flight");
    end
    @(negedge clk_i);
    flush_i = 1'b0;
    #1;
    if (busy_o || out_valid_o) begin
      other_errs++;
      $display("Pipeline still held a valid operation one cycle after flush");
    end
  endtask

  // -------------------------------------------------------------------
  // Output back-pressure
  // -------------------------------------------------------------------
  initial begin : ready_drive
    void'($urandom(3276));
    forever begin
      @(negedge clk_i);
      if (ready_mode == 0) begin
        out_ready_i = ($urandom % 100) >= 30;
      end else begin
        out_ready_i = (ready_mode == 1);
      end
    end
  end

  // -------------------------------------------------------------------
  // Output monitor
  // -------------------------------------------------------------------
  logic                stalled;
  logic [31:0]         held_result;
  logic [3:0]          held_tag;
  fp_fmt_pkg::status_t held_status;

  always begin : monitor
    expect_t e;
    string   nm;
    @(negedge clk_i);
    #2;
    if (!arst_n_i || flush_i) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        if (!out_valid_o || result_o !== held_result || tag_o !== held_tag ||
            status_o !== held_status) begin
          other_errs++;
          $display("Output dropped or changed while out_ready_i was low (tag %h)", held_tag);
        end
      end
      if (out_valid_o && out_ready_i) begin
        stalled = 1'b0;
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("Output with tag %h appeared with no operation pending", tag_o);
        end else begin
          e  = exp_q.pop_front();
          nm = exp_name_q.pop_front();
          if (tag_o !== e.tag) begin
            mismatch_errs++;
            $display("MISMATCH %s tag: expected %h actual %h", nm, e.tag, tag_o);
          end
          if (result_o !== e.result) begin
            mismatch_errs++;
            $display("MISMATCH %s result: expected %h actual %h", nm, e.result, result_o);
          end
          if (status_o !== e.status) begin
            mismatch_errs++;
            $display("MISMATCH %s status: expected %b actual %b", nm, e.status, status_o);
          end
          if (extension_bit_o !== 1'b1) begin
            mismatch_errs++;
            $display("MISMATCH %s extension bit: expected 1 actual %b", nm, extension_bit_o);
          end
        end
      end else begin
        stalled     = out_valid_o;
        held_result = result_o;
        held_tag    = tag_o;
        held_status = status_o;
      end
    end
  end

  // Budget of 40 cycles per table entry plus setup
  initial begin : watchdog
    wait (table_built);
    repeat (40 * tbl.size() + 200) @(posedge clk_i);
    $display("Watchdog expired before the test sequence completed");
    $display("=== FAIL ===");
    $finish;
  end

  // -------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------
  initial begin
    clk_i         = 1'b0;
    arst_n_i      = 1'b0;
    req_i         = '0;
    tag_i         = '0;
    in_valid_i    = 1'b0;
    flush_i       = 1'b0;
    out_ready_i   = 1'b0;
    next_tag      = '0;
    ready_mode    = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    stalled       = 1'b0;

    // name, op, fmt, vec, mask, a, b, expected result, expected status
    add_vector("f32_sgnj", slice_op_pkg::SGNJ, fp_fmt_pkg::FP32, 0, 2'b01,
               32'h3F80_0000, 32'hC000_0000, 32'hBF80_0000, 5'b0);
    add_vector("f32_sgnjn", slice_op_pkg::SGNJN, fp_fmt_pkg::FP32, 0, 2'b01,
               32'h3F80_0000, 32'hC000_0000, 32'h3F80_0000, 5'b0);
    add_vector("f32_sgnjx", slice_op_pkg::SGNJX, fp_fmt_pkg::FP32, 0, 2'b01,
               32'hBF80_0000, 32'hC000_0000, 32'h3F80_0000, 5'b0);
    add_vector("f32_min", slice_op_pkg::MIN, fp_fmt_pkg::FP32, 0, 2'b01,
               32'h4000_0000, 32'hBF80_0000, 32'hBF80_0000, 5'b0);
    add_vector("f32_max", slice_op_pkg::MAX, fp_fmt_pkg::FP32, 0, 2'b01,
               32'h4000_0000, 32'hBF80_0000, 32'h4000_0000, 5'b0);
    add_vector("f32_min_zeros", slice_op_pkg::MIN, fp_fmt_pkg::FP32, 0, 2'b01,
               32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 5'b0);
    add_vector("f32_max_zeros", slice_op_pkg::MAX, fp_fmt_pkg::FP32, 0, 2'b01,
               32'h0000_0000, 32'h8000_0000, 32'h0000_0000, 5'b0);
    add_vector("f32_min_qnan", slice_op_pkg::MIN, fp_fmt_pkg::FP32, 0, 2'b01,
               32'h7FC0_0000, 32'h3F80_0000, 32'h3F80_0000, 5'b0);
    add_vector("f32_max_2nan", slice_op_pkg::MAX, fp_fmt_pkg::FP32, 0, 2'b01,
               32'h7FC0_0001, 32'hFFC0_0000, 32'h7FC0_0000, 5'b0);
    add_vector("f32_min_snan", slice_op_pkg::MIN, fp_fmt_pkg::FP32, 0, 2'b01,
               32'h7F80_0001, 32'h4000_0000, 32'h4000_0000, NV);
    add_vector("f16_sgnj", slice_op_pkg::SGNJ, fp_fmt_pkg::FP16, 0, 2'b01,
               32'h1234_3C00, 32'h0000_C000, 32'hFFFF_BC00, 5'b0);
    add_vector("f16_max", slice_op_pkg::MAX, fp_fmt_pkg::FP16, 0, 2'b01,
               32'hABCD_4000, 32'h0000_3C00, 32'hFFFF_4000, 5'b0);
    add_vector("f16_min_2nan", slice_op_pkg::MIN, fp_fmt_pkg::FP16, 0, 2'b01,
               32'h0000_7E01, 32'h0000_FE00, 32'hFFFF_7E00, 5'b0);
    add_vector("v16_min", slice_op_pkg::MIN, fp_fmt_pkg::FP16, 1, 2'b11,
               32'h4000_3C00, 32'hBC00_4200, 32'hBC00_3C00, 5'b0);
    add_vector("v16_sgnjx", slice_op_pkg::SGNJX, fp_fmt_pkg::FP16, 1, 2'b11,
               32'h3C00_C000, 32'hBC00_BC00, 32'hBC00_4000, 5'b0);
    add_vector("v16_snan_lane1", slice_op_pkg::MAX, fp_fmt_pkg::FP16, 1, 2'b11,
               32'h7C01_3C00, 32'h4000_4000, 32'h4000_4000, NV);
    add_vector("v16_snan_masked", slice_op_pkg::MAX, fp_fmt_pkg::FP16, 1, 2'b01,
               32'h7C01_3C00, 32'h4000_4000, 32'h4000_4000, 5'b0);
    table_built = 1'b1;

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    #1;
    if (out_valid_o !== 1'b0 || busy_o !== 1'b0 || in_ready_o !== 1'b1) begin
      other_errs++;
      $display("Handshake outputs not in their reset state after reset release");
    end

    // Whole table under random back-pressure
    for (int i = 0; i < tbl.size(); i++) begin
      apply_entry(i, 1'b1);
    end
    idle_inputs();
    wait_drain();

    ready_mode = 1;
    check_latency();
    wait_drain();

    ready_mode = 2;
    check_flush();

    // Pipeline must keep working after the flush
    ready_mode = 0;
    apply_entry(3, 1'b1);
    apply_entry(15, 1'b1);
    idle_inputs();
    wait_drain();
    repeat (4) @(negedge clk_i);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/fp_noncomp_slice.sv ====
// ---------------------------------------------------------------------
// SIMD slice for FP32/FP16 sign injection and min/max
// Valid/ready in and out, NumPipeRegs cycles of latency
// Lane 1 runs only for vectorial FP16 requests
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fp_noncomp_slice #(
  parameter int unsigned NumPipeRegs = 2,
  parameter type         tag_t       = logic [3:0]
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  slice_op_pkg::slice_req_t     req_i,
  input  tag_t                         tag_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic                         flush_i,
  output logic [fp_fmt_pkg::FLEN-1:0]  result_o,
  output fp_fmt_pkg::status_t          status_o,
  output logic                         extension_bit_o,
  output tag_t                         tag_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic                         busy_o
);

  localparam int unsigned NL = fp_fmt_pkg::NUM_LANES;

  logic [NL-1:0][fp_fmt_pkg::FLEN-1:0] lane_a, lane_b, lane_result;
  logic [NL-1:0]                       lane_active, lane_mask;
  fp_fmt_pkg::status_t [NL-1:0]        lane_status;
  logic [NumPipeRegs-1:0]              stage_en;
  slice_op_pkg::slice_aux_t            in_aux, out_aux;

  assign in_aux.fmt         = req_i.fmt;
  assign in_aux.lane_active = lane_active;

  lane_operand_prep u_prep (
    .req_i         (req_i),
    .lane_a_o      (lane_a),
    .lane_b_o      (lane_b),
    .lane_active_o (lane_active)
  );

  slice_pipe_ctrl #(
    .NumPipeRegs (NumPipeRegs),
    .tag_t       (tag_t),
    .aux_t       (slice_op_pkg::slice_aux_t)
  ) u_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .tag_i       (tag_i),
    .aux_i       (in_aux),
    .flush_i     (flush_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .tag_o       (tag_o),
    .aux_o       (out_aux),
    .stage_en_o  (stage_en),
    .busy_o      (busy_o)
  );

  for (genvar k = 0; k < NL; k++) begin : gen_lane
    noncomp_lane #(
      .NumPipeRegs (NumPipeRegs),
      .HasFp32     (k == 0)
    ) u_lane (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .op_i       (req_i.op),
      .fmt_i      (req_i.fmt),
      .a_i        (lane_a[k]),
      .b_i        (lane_b[k]),
      .mask_i     (req_i.simd_mask[k]),
      .stage_en_i (stage_en),
      .result_o   (lane_result[k]),
      .status_o   (lane_status[k]),
      .mask_o     (lane_mask[k])
    );
  end

  result_pack u_pack (
    .lane_result_i   (lane_result),
    .lane_status_i   (lane_status),
    .lane_mask_i     (lane_mask),
    .aux_i           (out_aux),
    .result_o        (result_o),
    .status_o        (status_o),
    .extension_bit_o (extension_bit_o)
  );

endmodule

`default_nettype wire

// ==== hdl/result_pack.sv ====
// ---------------------------------------------------------------------
// Packs lane results by format and folds lane flags into one status
// Unused FP16 upper half is NaN-boxed with ones
// Flags count only from lanes that were active and masked in
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module result_pack (
  input  logic [fp_fmt_pkg::NUM_LANES-1:0][fp_fmt_pkg::FLEN-1:0] lane_result_i,
  input  fp_fmt_pkg::status_t [fp_fmt_pkg::NUM_LANES-1:0]        lane_status_i,
  input  logic [fp_fmt_pkg::NUM_LANES-1:0]                       lane_mask_i,
  input  slice_op_pkg::slice_aux_t                               aux_i,
  output logic [fp_fmt_pkg::FLEN-1:0]                            result_o,
  output fp_fmt_pkg::status_t                                    status_o,
  output logic                                                   extension_bit_o
);

  localparam int unsigned HW = fp_fmt_pkg::FP16_WIDTH;

  logic [HW-1:0] upper_half;

  // Lane 1 only contributes when it actually ran
  assign upper_half = aux_i.lane_active[1] ? lane_result_i[1][HW-1:0] : '1;

  always_comb begin
    if (aux_i.fmt == fp_fmt_pkg::FP32) begin
      result_o = lane_result_i[0];
    end else begin
      result_o = {upper_half, lane_result_i[0][HW-1:0]};
    end
  end

  // -------------------------------------------------------------------
  // Status collapse
  // -------------------------------------------------------------------
  always_comb begin
    fp_fmt_pkg::status_t acc;
    acc = '0;
    for (int unsigned k = 0; k < fp_fmt_pkg::NUM_LANES; k++) begin
      if (aux_i.lane_active[k] && lane_mask_i[k]) begin
        acc = acc | lane_status_i[k];
      end
    end
    status_o = acc;
  end

  // All results are floats, always NaN-boxed
  assign extension_bit_o = 1'b1;

endmodule

`default_nettype wire

// ==== hdl/noncomp_lane.sv ====
// ---------------------------------------------------------------------
// One SIMD lane for sign injection and min/max
// Works at 32 bits only for FP32 with HasFp32 set, else at 16 bits
// Result is computed up front, then delayed by NumPipeRegs stages
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module noncomp_lane #(
  parameter int unsigned NumPipeRegs = 2,
  parameter bit          HasFp32     = 1'b1
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  slice_op_pkg::noncomp_op_e     op_i,
  input  fp_fmt_pkg::fp_fmt_e           fmt_i,
  input  logic [fp_fmt_pkg::FLEN-1:0]   a_i,
  input  logic [fp_fmt_pkg::FLEN-1:0]   b_i,
  input  logic                          mask_i,
  input  logic [NumPipeRegs-1:0]        stage_en_i,
  output logic [fp_fmt_pkg::FLEN-1:0]   result_o,
  output fp_fmt_pkg::status_t           status_o,
  output logic                          mask_o
);

  logic        is32;
  logic        sign_a, sign_b, inj_sign;
  logic [30:0] mag_a, mag_b;
  logic        nan_a, nan_b, snan_a, snan_b;
  logic        a_lt_b, is_minmax;

  // Stage 0 holds the combinational result
  logic [fp_fmt_pkg::FLEN-1:0] res_q  [0:NumPipeRegs];
  fp_fmt_pkg::status_t         sts_q  [0:NumPipeRegs];
  logic                        mask_q [0:NumPipeRegs];

  // -------------------------------------------------------------------
  // Operand classification
  // -------------------------------------------------------------------
  assign is32   = HasFp32 && (fmt_i == fp_fmt_pkg::FP32);
  assign sign_a = is32 ? a_i[31] : a_i[15];
  assign sign_b = is32 ? b_i[31] : b_i[15];
  assign mag_a  = is32 ? a_i[30:0] : {16'b0, a_i[14:0]};
  assign mag_b  = is32 ? b_i[30:0] : {16'b0, b_i[14:0]};

  // Exponent all ones with a nonzero mantissa, quiet bit clear for sNaN
  assign nan_a  = is32 ? (&a_i[30:23] && |a_i[22:0]) : (&a_i[14:10] && |a_i[9:0]);
  assign nan_b  = is32 ? (&b_i[30:23] && |b_i[22:0]) : (&b_i[14:10] && |b_i[9:0]);
  assign snan_a = nan_a && !(is32 ? a_i[22] : a_i[9]);
  assign snan_b = nan_b && !(is32 ? b_i[22] : b_i[9]);

  // Sign-magnitude order, so -0 sorts below +0
  assign a_lt_b = (sign_a != sign_b) ? sign_a :
                  sign_a ? (mag_a > mag_b) : (mag_a < mag_b);

  assign is_minmax = (op_i == slice_op_pkg::MIN) || (op_i == slice_op_pkg::MAX);

  always_comb begin
    case (op_i)
      slice_op_pkg::SGNJN: inj_sign = ~sign_b;
      slice_op_pkg::SGNJX: inj_sign = sign_a ^ sign_b;
      default:             inj_sign = sign_b;
    endcase
  end

  always_comb begin
    sts_q[0]    = '0;
    sts_q[0].nv = is_minmax && (snan_a || snan_b);
    if (!is_minmax) begin
      res_q[0] = is32 ? {inj_sign, a_i[30:0]} : {16'hFFFF, inj_sign, a_i[14:0]};
    end else if (nan_a && nan_b) begin
      res_q[0] = is32 ? fp_fmt_pkg::FP32_QNAN : {16'hFFFF, fp_fmt_pkg::FP16_QNAN};
    end else if (nan_a) begin
      res_q[0] = b_i;
    end else if (nan_b) begin
      res_q[0] = a_i;
    end else if (op_i == slice_op_pkg::MIN) begin
      res_q[0] = a_lt_b ? a_i : b_i;
    end else begin
      res_q[0] = a_lt_b ? b_i : a_i;
    end
  end

  assign mask_q[0] = mask_i;

  // -------------------------------------------------------------------
  // Output pipeline, advanced by the control chain
  // -------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        sts_q[i+1]  <= '0;
        mask_q[i+1] <= 1'b0;
      end else if (stage_en_i[i]) begin
        sts_q[i+1]  <= sts_q[i];
        mask_q[i+1] <= mask_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_en_i[i]) begin
        res_q[i+1] <= res_q[i];
      end
    end
  end

  assign result_o = res_q[NumPipeRegs];
  assign status_o = sts_q[NumPipeRegs];
  assign mask_o   = mask_q[NumPipeRegs];

endmodule

`default_nettype wire

// ==== hdl/lane_operand_prep.sv ====
// ---------------------------------------------------------------------
// Splits the packed operands into per-lane fields
// Upper bits of each lane field are don't-care for the lane
// Lane 1 is only active for vectorial FP16
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module lane_operand_prep (
  input  slice_op_pkg::slice_req_t                                   req_i,
  output logic [fp_fmt_pkg::NUM_LANES-1:0][fp_fmt_pkg::FLEN-1:0]     lane_a_o,
  output logic [fp_fmt_pkg::NUM_LANES-1:0][fp_fmt_pkg::FLEN-1:0]     lane_b_o,
  output logic [fp_fmt_pkg::NUM_LANES-1:0]                           lane_active_o
);

  logic is_fp16;

  assign is_fp16 = (req_i.fmt == fp_fmt_pkg::FP16);

  always_comb begin
    int unsigned fmt_width;
    fmt_width = is_fp16 ? fp_fmt_pkg::FP16_WIDTH : fp_fmt_pkg::FP32_WIDTH;
    for (int unsigned k = 0; k < fp_fmt_pkg::NUM_LANES; k++) begin
      // Lane k sees its element at the bottom
      lane_a_o[k] = req_i.a >> (k * fmt_width);
      lane_b_o[k] = req_i.b >> (k * fmt_width);
      // Lane 0 always runs, upper lanes need a vectorial FP16 op
      lane_active_o[k] = (k == 0) | (req_i.vectorial & is_fp16);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/slice_pipe_ctrl.sv ====
// ---------------------------------------------------------------------
// Valid/ready stage chain for the slice pipeline
// Exports one load enable per stage; datapath regs must use them
// flush_i drops every valid bit, stage payload is left as is
// NumPipeRegs = 0 gives a purely combinational pass-through
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module slice_pipe_ctrl #(
  parameter int unsigned NumPipeRegs = 2,
  parameter type         tag_t       = logic,
  parameter type         aux_t       = logic
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  tag_t                   tag_i,
  input  aux_t                   aux_i,
  input  logic                   flush_i,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output tag_t                   tag_o,
  output aux_t                   aux_o,
  output logic [NumPipeRegs-1:0] stage_en_o,
  output logic                   busy_o
);

  // Index 0 is the input side, index i the output of register stage i
  logic valid [0:NumPipeRegs];
  logic ready [0:NumPipeRegs];
  tag_t tag_q [0:NumPipeRegs];
  aux_t aux_q [0:NumPipeRegs];

  assign valid[0] = in_valid_i;
  assign tag_q[0] = tag_i;
  assign aux_q[0] = aux_i;

  assign ready[NumPipeRegs] = out_ready_i;

  // -------------------------------------------------------------------
  // Register stages
  // -------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    // A stage can take new data when empty or when it is draining
    assign ready[i]      = ready[i+1] | ~valid[i+1];
    assign stage_en_o[i] = ready[i] & valid[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid[i+1] <= valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_en_o[i]) begin
        tag_q[i+1] <= tag_q[i];
        aux_q[i+1] <= aux_q[i];
      end
    end
  end

  if (NumPipeRegs == 0) begin : gen_no_stage
    assign stage_en_o = '0;
  end

  assign in_ready_o  = ready[0];
  assign out_valid_o = valid[NumPipeRegs];
  assign tag_o       = tag_q[NumPipeRegs];
  assign aux_o       = aux_q[NumPipeRegs];

  always_comb begin
    busy_o = 1'b0;
    for (int i = 1; i <= int'(NumPipeRegs); i++) begin
      busy_o = busy_o | valid[i];
    end
  end

  // -------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------
  if (NumPipeRegs > 0) begin : gen_checks
    // Stalled output must hold until the consumer takes it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (out_valid_o && !out_ready_i && !flush_i) |=> (out_valid_o && $stable(tag_o)));
  end

endmodule

`default_nettype wire

// ==== hdl/slice_op_pkg.sv ====
// ---------------------------------------------------------------------
// Operation encoding and request/aux records of the non-comp slice
// Depends on fp_fmt_pkg, which must be compiled first
// ---------------------------------------------------------------------
`default_nettype none

package slice_op_pkg;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MIN   = 3'd3,
    MAX   = 3'd4
  } noncomp_op_e;

  // One request as presented at the slice input
  typedef struct packed {
    noncomp_op_e                          op;
    fp_fmt_pkg::fp_fmt_e                  fmt;
    logic                                 vectorial;
    logic [fp_fmt_pkg::FLEN-1:0]          a;
    logic [fp_fmt_pkg::FLEN-1:0]          b;
    logic [fp_fmt_pkg::NUM_LANES-1:0]     simd_mask;
  } slice_req_t;

  // Side data that rides along the control pipeline
  typedef struct packed {
    fp_fmt_pkg::fp_fmt_e                  fmt;
    logic [fp_fmt_pkg::NUM_LANES-1:0]     lane_active;
  } slice_aux_t;

endpackage

`default_nettype wire

// ==== hdl/fp_fmt_pkg.sv ====
// ---------------------------------------------------------------------
// Float formats and status flags shared by the whole slice
// Only FP32 and FP16 exist; the datapath is fixed at 32 bits
// Two SIMD lanes, the upper one only ever holds FP16
// ---------------------------------------------------------------------
`default_nettype none

package fp_fmt_pkg;

  // Datapath and lane geometry
  localparam int unsigned FLEN      = 32;
  localparam int unsigned NUM_LANES = 2;

  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;

  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  // Canonical quiet NaNs
  localparam logic [FP32_WIDTH-1:0] FP32_QNAN = 32'h7FC0_0000;
  localparam logic [FP16_WIDTH-1:0] FP16_QNAN = 16'h7E00;

  // IEEE 754 exception flags, in the usual fflags order
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

endpackage

`default_nettype wire
